// ==== common/uart_string_cfg.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart string link constants
// frame mark, string buffer size and default bit time
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef UART_STRING_CFG_SVH
`define UART_STRING_CFG_SVH

// ascii "&", opens and closes a frame
`define FRAME_MARK 8'h26

// string buffer in bytes, string ports are 8x this wide
`define STR_MAX_BYTES 16

// length fields must hold STR_MAX_BYTES itself
`define LEN_W 5

// default bit time in clocks
`define CLKS_PER_BIT 8

`endif

// ==== common/uart_string_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart string link types
// state encodings shared by the framers, the byte uarts and the checkers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package uart_string_pkg;

	// send framer, one state per byte of the "&&content&&" frame
	typedef enum logic [2:0] {
		TX_IDLE   = 3'd0,
		TX_OPEN1  = 3'd1,
		TX_OPEN2  = 3'd2,
		TX_BODY   = 3'd3,
		TX_CLOSE1 = 3'd4,
		TX_CLOSE2 = 3'd5,
		TX_DONE   = 3'd6
	} tx_frame_state_e;

	// receive framer
	typedef enum logic [1:0] {
		RX_HUNT  = 2'd0,
		RX_OPEN2 = 2'd1,
		RX_BODY  = 2'd2,
		RX_ESC   = 2'd3
	} rx_frame_state_e;

	// bit level states used by both byte uarts
	typedef enum logic [1:0] {
		BIT_IDLE  = 2'd0,
		BIT_START = 2'd1,
		BIT_DATA  = 2'd2,
		BIT_STOP  = 2'd3
	} uart_bit_state_e;

endpackage

// ==== uart/uart_tx.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte uart transmitter
// one start bit, eight data bits lsb first, two stop bits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "uart_string_cfg.svh"

module uart_tx import uart_string_pkg::*; #(
	parameter int CLKS_PER_BIT = `CLKS_PER_BIT
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] byte_data,
	input  logic       byte_req,
	output logic       byte_done,
	output logic       txd
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

	uart_bit_state_e state;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_cnt;
	logic [7:0]       shift_q;
	logic             bit_end;

	assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= BIT_IDLE;
			clk_cnt   <= '0;
			bit_cnt   <= '0;
			txd       <= 1'b1;
			byte_done <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			clk_cnt   <= bit_end ? '0 : clk_cnt + 1'b1;
			case (state)
				BIT_IDLE: begin
					// requests while busy are simply not seen here
					clk_cnt <= '0;
					if (byte_req) begin
						txd   <= 1'b0;
						state <= BIT_START;
					end
				end
				BIT_START: begin
					if (bit_end) begin
						txd     <= shift_q[0];
						bit_cnt <= '0;
						state   <= BIT_DATA;
					end
				end
				BIT_DATA: begin
					if (bit_end) begin
						if (bit_cnt == 3'd7) begin
							txd     <= 1'b1;
							bit_cnt <= '0;
							state   <= BIT_STOP;
						end else begin
							txd     <= shift_q[0];
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				BIT_STOP: begin
					// two stop bit times, then report the byte as sent
					if (bit_end) begin
						if (bit_cnt == 3'd1) begin
							byte_done <= 1'b1;
							state     <= BIT_IDLE;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
			endcase
		end
	end

	// data shifter, bit 0 is always the next bit to go out
	always_ff @(posedge sys_clk) begin
		if (state == BIT_IDLE && byte_req)
			shift_q <= byte_data;
		else if (bit_end && (state == BIT_START || state == BIT_DATA))
			shift_q <= shift_q >> 1;
	end

endmodule

// ==== uart/uart_rx.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte uart receiver
// synchronizes the line, samples each bit at its middle and
// pulses rx_byte_vld at mid stop bit when the frame is good
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "uart_string_cfg.svh"

module uart_rx import uart_string_pkg::*; #(
	parameter int CLKS_PER_BIT = `CLKS_PER_BIT
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       rxd,
	output logic [7:0] rx_byte,
	output logic       rx_byte_vld
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
	localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(CLKS_PER_BIT / 2 - 1);

	uart_bit_state_e state;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_cnt;
	logic [7:0]       shift_q;
	logic             rxd_meta;
	logic             rxd_sync;
	logic             rxd_prev;
	logic             bit_end;
	logic             start_edge;

	assign bit_end    = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign start_edge = rxd_prev & ~rxd_sync;

	// two flop synchronizer plus one stage for edge detection
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state       <= BIT_IDLE;
			clk_cnt     <= '0;
			bit_cnt     <= '0;
			rx_byte_vld <= 1'b0;
		end else begin
			rx_byte_vld <= 1'b0;
			clk_cnt     <= bit_end ? '0 : clk_cnt + 1'b1;
			case (state)
				BIT_IDLE: begin
					clk_cnt <= '0;
					if (start_edge)
						state <= BIT_START;
				end
				BIT_START: begin
					// half a bit in, a glitch would already be high again
					if (clk_cnt == HALF_CNT) begin
						clk_cnt <= '0;
						bit_cnt <= '0;
						state   <= rxd_sync ? BIT_IDLE : BIT_DATA;
					end
				end
				BIT_DATA: begin
					if (bit_end) begin
						if (bit_cnt == 3'd7)
							state <= BIT_STOP;
						else
							bit_cnt <= bit_cnt + 1'b1;
					end
				end
				BIT_STOP: begin
					// framing error drops the byte silently
					if (bit_end) begin
						rx_byte_vld <= rxd_sync;
						state       <= BIT_IDLE;
					end
				end
			endcase
		end
	end

	// lsb arrives first, so shift in from the top
	always_ff @(posedge sys_clk) begin
		if (state == BIT_DATA && bit_end)
			shift_q <= {rxd_sync, shift_q[7:1]};
		if (state == BIT_STOP && bit_end && rxd_sync)
			rx_byte <= shift_q;
	end

endmodule

// ==== hdl/string_frame_tx.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// string send framer
// wraps a captured string as "&&content&&" and feeds it byte by
// byte to the uart transmitter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "uart_string_cfg.svh"

module string_frame_tx import uart_string_pkg::*; (
	input  logic                         sys_clk,
	input  logic                         sys_rst_n,
	input  logic [`STR_MAX_BYTES*8-1:0]  tx_string,
	input  logic [`LEN_W-1:0]            tx_length,
	input  logic                         tx_req,
	output logic                         tx_busy,
	output logic                         tx_done,
	output logic [7:0]                   byte_data,
	output logic                         byte_req,
	input  logic                         byte_done
);

	tx_frame_state_e state;
	logic [`STR_MAX_BYTES*8-1:0] str_q;
	logic [`LEN_W-1:0]           len_q;
	logic [`LEN_W-1:0]           byte_cnt;

	assign tx_busy = (state != TX_IDLE);
	assign tx_done = (state == TX_DONE);

	// string and length held for the whole frame
	always_ff @(posedge sys_clk) begin
		if (state == TX_IDLE && tx_req) begin
			str_q <= tx_string;
			len_q <= tx_length;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= TX_IDLE;
			byte_cnt  <= '0;
			byte_req  <= 1'b0;
			byte_data <= '0;
		end else begin
			byte_req <= 1'b0;
			case (state)
				TX_IDLE: begin
					byte_cnt <= '0;
					if (tx_req) begin
						byte_data <= `FRAME_MARK;
						byte_req  <= 1'b1;
						state     <= TX_OPEN1;
					end
				end
				TX_OPEN1: begin
					if (byte_done) begin
						byte_data <= `FRAME_MARK;
						byte_req  <= 1'b1;
						state     <= TX_OPEN2;
					end
				end
				TX_OPEN2, TX_BODY: begin
					// empty strings go straight to the closing marks
					if (byte_done) begin
						byte_req <= 1'b1;
						if (byte_cnt == len_q) begin
							byte_data <= `FRAME_MARK;
							state     <= TX_CLOSE1;
						end else begin
							byte_data <= str_q[byte_cnt * 8 +: 8];
							byte_cnt  <= byte_cnt + 1'b1;
							state     <= TX_BODY;
						end
					end
				end
				TX_CLOSE1: begin
					if (byte_done) begin
						byte_data <= `FRAME_MARK;
						byte_req  <= 1'b1;
						state     <= TX_CLOSE2;
					end
				end
				TX_CLOSE2: begin
					if (byte_done)
						state <= TX_DONE;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

endmodule

// ==== hdl/string_frame_rx.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// string receive framer
// hunts for "&&", collects content up to the next "&&" and
// publishes string, length and overflow with a done pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "uart_string_cfg.svh"

module string_frame_rx import uart_string_pkg::*; (
	input  logic                         sys_clk,
	input  logic                         sys_rst_n,
	input  logic [7:0]                   rx_byte,
	input  logic                         rx_byte_vld,
	output logic [`STR_MAX_BYTES*8-1:0]  rx_string,
	output logic [`LEN_W-1:0]            rx_length,
	output logic                         rx_busy,
	output logic                         rx_done,
	output logic                         rx_overflow
);

	rx_frame_state_e state;
	logic [`STR_MAX_BYTES*8-1:0] buf_q;
	logic [`LEN_W-1:0]           len_q;
	logic [`LEN_W-1:0]           len_next1;
	logic                        ovf_q;
	logic                        is_mark;
	logic                        frame_start;
	logic                        frame_end;
	logic                        store_one;
	logic                        store_esc;
	logic                        wr0;
	logic                        wr1;
	logic [7:0]                  wr0_data;

	assign rx_busy     = (state != RX_HUNT);
	assign is_mark     = (rx_byte == `FRAME_MARK);
	assign frame_start = rx_byte_vld && is_mark && state == RX_OPEN2;
	assign frame_end   = rx_byte_vld && is_mark && state == RX_ESC;
	assign store_one   = rx_byte_vld && !is_mark && state == RX_BODY;
	// a lone mark inside the content is kept together with its follower
	assign store_esc   = rx_byte_vld && !is_mark && state == RX_ESC;
	assign len_next1   = len_q + 1'b1;
	assign wr0         = (store_one || store_esc) && len_q < `LEN_W'(`STR_MAX_BYTES);
	assign wr1         = store_esc && len_next1 < `LEN_W'(`STR_MAX_BYTES);
	assign wr0_data    = store_esc ? `FRAME_MARK : rx_byte;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state       <= RX_HUNT;
			len_q       <= '0;
			ovf_q       <= 1'b0;
			rx_length   <= '0;
			rx_overflow <= 1'b0;
			rx_done     <= 1'b0;
		end else begin
			rx_done <= frame_end;
			if (rx_byte_vld) begin
				case (state)
					RX_HUNT:  state <= is_mark ? RX_OPEN2 : RX_HUNT;
					RX_OPEN2: state <= is_mark ? RX_BODY : RX_HUNT;
					RX_BODY:  state <= is_mark ? RX_ESC : RX_BODY;
					RX_ESC:   state <= is_mark ? RX_HUNT : RX_BODY;
				endcase
			end
			if (frame_start) begin
				len_q <= '0;
				ovf_q <= 1'b0;
			end else begin
				len_q <= len_q + `LEN_W'(wr0) + `LEN_W'(wr1);
				if ((store_one && !wr0) || (store_esc && !wr1))
					ovf_q <= 1'b1;
			end
			if (frame_end) begin
				rx_length   <= len_q;
				rx_overflow <= ovf_q;
			end
		end
	end

	// content buffer, published only on a complete frame
	always_ff @(posedge sys_clk) begin
		if (frame_start) begin
			buf_q <= '0;
		end else begin
			for (int i = 0; i < `STR_MAX_BYTES; i++) begin
				if (wr0 && len_q == `LEN_W'(i))
					buf_q[i*8 +: 8] <= wr0_data;
				if (wr1 && len_next1 == `LEN_W'(i))
					buf_q[i*8 +: 8] <= rx_byte;
			end
		end
		if (frame_end)
			rx_string <= buf_q;
	end

endmodule

// ==== hdl/uart_string_handle.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart string link top
// send and receive framers joined to the byte uarts and the pins
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "uart_string_cfg.svh"

module uart_string_handle #(
	parameter int CLKS_PER_BIT = `CLKS_PER_BIT
) (
	input  logic                         sys_clk,
	input  logic                         sys_rst_n,
	input  logic [`STR_MAX_BYTES*8-1:0]  tx_string,
	input  logic [`LEN_W-1:0]            tx_length,
	input  logic                         tx_req,
	output logic                         tx_busy,
	output logic                         tx_done,
	output logic [`STR_MAX_BYTES*8-1:0]  rx_string,
	output logic [`LEN_W-1:0]            rx_length,
	output logic                         rx_busy,
	output logic                         rx_done,
	output logic                         rx_overflow,
	input  logic                         uart_rx_port,
	output logic                         uart_tx_port
);

	logic [7:0] tx_byte_data;
	logic       tx_byte_req;
	logic       tx_byte_done;
	logic [7:0] rx_byte;
	logic       rx_byte_vld;

	// send path
	string_frame_tx u_frame_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.byte_data (tx_byte_data),
		.byte_req  (tx_byte_req),
		.byte_done (tx_byte_done)
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_data (tx_byte_data),
		.byte_req  (tx_byte_req),
		.byte_done (tx_byte_done),
		.txd       (uart_tx_port)
	);

	// receive path
	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.rxd         (uart_rx_port),
		.rx_byte     (rx_byte),
		.rx_byte_vld (rx_byte_vld)
	);

	string_frame_rx u_frame_rx (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.rx_byte     (rx_byte),
		.rx_byte_vld (rx_byte_vld),
		.rx_string   (rx_string),
		.rx_length   (rx_length),
		.rx_busy     (rx_busy),
		.rx_done     (rx_done),
		.rx_overflow (rx_overflow)
	);

endmodule

// ==== bench/uart_string_handle_sva.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart string link checkers
// byte handshake, tx_done pulse width and rx frame end rules
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uart_string_handle_sva import uart_string_pkg::*; (
	input logic            sys_clk,
	input logic            sys_rst_n,
	input logic            byte_req,
	input logic            byte_done,
	input logic            tx_done,
	input rx_frame_state_e rx_state,
	input logic            rx_done
);

	// a byte is outstanding from byte_req until its byte_done
	logic byte_open;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			byte_open <= 1'b0;
		else if (byte_req)
			byte_open <= 1'b1;
		else if (byte_done)
			byte_open <= 1'b0;
	end

	req_when_free: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		byte_req |-> !byte_open)
		else $error("byte_req while a byte is still being sent");

	tx_done_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |=> !tx_done)
		else $error("tx_done longer than one cycle");

	rx_done_from_esc: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_done |-> ($past(rx_state) == RX_ESC && rx_state == RX_HUNT))
		else $error("rx_done without leaving RX_ESC");

endmodule

// send framer, receive side inputs held idle
bind string_frame_tx uart_string_handle_sva u_tx_sva (
	.sys_clk   (sys_clk),
	.sys_rst_n (sys_rst_n),
	.byte_req  (byte_req),
	.byte_done (byte_done),
	.tx_done   (tx_done),
	.rx_state  (RX_HUNT),
	.rx_done   (1'b0)
);

bind string_frame_rx uart_string_handle_sva u_rx_sva (
	.sys_clk   (sys_clk),
	.sys_rst_n (sys_rst_n),
	.byte_req  (1'b0),
	.byte_done (1'b0),
	.tx_done   (1'b0),
	.rx_state  (state),
	.rx_done   (rx_done)
);

// ==== bench/uart_string_handle_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart string link testbench
// replays the stim file in loopback or raw wire mode and checks
// the received string, length and overflow of every frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "uart_string_cfg.svh"

module uart_string_handle_tb;

	localparam int STR_W      = `STR_MAX_BYTES * 8;
	localparam int BIT_CLKS   = `CLKS_PER_BIT;
	// a full 20 byte frame takes about 1800 clocks
	localparam int DONE_LIMIT = 3000;

	logic              sys_clk;
	logic              sys_rst_n;
	logic [STR_W-1:0]  tx_string;
	logic [`LEN_W-1:0] tx_length;
	logic              tx_req;
	logic              tx_busy;
	logic              tx_done;
	logic [STR_W-1:0]  rx_string;
	logic [`LEN_W-1:0] rx_length;
	logic              rx_busy;
	logic              rx_done;
	logic              rx_overflow;
	logic              uart_rx_port;
	logic              uart_tx_port;
	logic              loop_mode;
	logic              wire_line;
	int                rx_done_cnt;

	// loopback ties the receiver to our own transmitter
	assign uart_rx_port = loop_mode ? uart_tx_port : wire_line;

	uart_string_handle uut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.rx_overflow  (rx_overflow),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	// rx_done can arrive before tx_done in loopback, so pulses are counted
	always @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			rx_done_cnt <= 0;
		else if (rx_done)
			rx_done_cnt <= rx_done_cnt + 1;
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_idle();
		assert (tx_busy === 1'b0 && tx_done === 1'b0)
			else stop_run($sformatf("Mismatch at %0t ns: send side not idle after reset", $time));
		assert (rx_busy === 1'b0 && rx_done === 1'b0 && rx_overflow === 1'b0)
			else stop_run($sformatf("Mismatch at %0t ns: receive side not idle after reset", $time));
		assert (rx_length === '0 && uart_tx_port === 1'b1)
			else stop_run($sformatf("Mismatch at %0t ns: rx_length or line wrong after reset",
				$time));
	endtask

	task automatic wait_tx_done(input int case_no);
		int cyc;
		cyc = 0;
		while (tx_done !== 1'b1) begin
			if (cyc == DONE_LIMIT)
				stop_run($sformatf("Timeout: no tx_done in case %0d", case_no));
			@(negedge sys_clk);
			cyc++;
		end
	endtask

	task automatic wait_rx_done(input int case_no, input int base);
		int cyc;
		cyc = 0;
		while (rx_done_cnt == base) begin
			if (cyc == DONE_LIMIT)
				stop_run($sformatf("Timeout: no rx_done in case %0d", case_no));
			@(negedge sys_clk);
			cyc++;
		end
	endtask

	// one byte on the wire, start bit, lsb first, two stop bits
	task automatic send_raw_byte(input logic [7:0] b);
		wire_line = 1'b0;
		repeat (BIT_CLKS) @(negedge sys_clk);
		for (int i = 0; i < 8; i++) begin
			wire_line = b[i];
			repeat (BIT_CLKS) @(negedge sys_clk);
		end
		wire_line = 1'b1;
		repeat (2 * BIT_CLKS) @(negedge sys_clk);
	endtask

	task automatic send_string(input int case_no, input int len, input logic [STR_W-1:0] str);
		tx_string = str;
		tx_length = len[`LEN_W-1:0];
		tx_req    = 1'b1;
		@(negedge sys_clk);
		tx_req = 1'b0;
		assert (tx_busy === 1'b1)
			else stop_run($sformatf("Mismatch at %0t ns: case %0d tx_busy low after request",
				$time, case_no));
		wait_tx_done(case_no);
		@(negedge sys_clk);
		assert (tx_busy === 1'b0)
			else stop_run($sformatf("Mismatch at %0t ns: case %0d tx_busy high after tx_done",
				$time, case_no));
	endtask

	task automatic run_case(input int case_no, input logic [7:0] mode, input int len,
		input logic [STR_W-1:0] data, input int exp_len, input logic [STR_W-1:0] exp_str,
		input int exp_ovf);
		int base;
		base = rx_done_cnt;
		if (mode == "L") begin
			loop_mode = 1'b1;
			send_string(case_no, len, data);
		end else if (mode == "W") begin
			loop_mode = 1'b0;
			for (int i = 0; i < len; i++)
				send_raw_byte(data[i*8 +: 8]);
		end else begin
			stop_run($sformatf("Unknown mode in stim line of case %0d", case_no));
		end
		if (exp_len < 0) begin
			// frame continues on the next line
			assert (rx_done_cnt == base && rx_busy === 1'b1)
				else stop_run($sformatf("Mismatch at %0t ns: case %0d frame not held open",
					$time, case_no));
		end else begin
			wait_rx_done(case_no, base);
			assert (rx_done_cnt == base + 1)
				else stop_run($sformatf("Mismatch at %0t ns: case %0d extra rx_done", $time,
					case_no));
			assert (int'(rx_length) == exp_len)
				else stop_run($sformatf("Mismatch at %0t ns: case %0d rx_length %0d, want %0d",
					$time, case_no, rx_length, exp_len));
			assert (rx_string === exp_str)
				else stop_run($sformatf("Mismatch at %0t ns: case %0d rx_string %h, want %h",
					$time, case_no, rx_string, exp_str));
			assert (rx_overflow === exp_ovf[0])
				else stop_run($sformatf("Mismatch at %0t ns: case %0d rx_overflow %b, want %0d",
					$time, case_no, rx_overflow, exp_ovf));
		end
		repeat (2 * BIT_CLKS) @(negedge sys_clk);
	endtask

	initial begin
		int               fd;
		int               code;
		int               ch;
		int               case_no;
		int               len;
		int               exp_len;
		int               exp_ovf;
		logic [7:0]       mode;
		logic [STR_W-1:0] data;
		logic [STR_W-1:0] exp_str;
		logic             at_end;

		sys_rst_n = 1'b0;
		tx_string = '0;
		tx_length = '0;
		tx_req    = 1'b0;
		loop_mode = 1'b0;
		wire_line = 1'b1;
		case_no   = 0;
		at_end    = 1'b0;
		repeat (8) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		@(negedge sys_clk);
		check_idle();

		fd = $fopen("bench/uart_string_stim.txt", "r");
		if (fd == 0)
			stop_run("Could not open the stimulus file bench/uart_string_stim.txt");
		while (!at_end) begin
			code = $fscanf(fd, " %c", mode);
			if (code != 1) begin
				at_end = 1'b1;
			end else if (mode == "#") begin
				// comment, skip to end of line
				ch = $fgetc(fd);
				while (ch != 10 && ch != -1)
					ch = $fgetc(fd);
			end else begin
				case_no++;
				code = $fscanf(fd, "%d %h %d %h %d", len, data, exp_len, exp_str, exp_ovf);
				if (code != 5)
					stop_run($sformatf("Stim line of case %0d is malformed", case_no));
				run_case(case_no, mode, len, data, exp_len, exp_str, exp_ovf);
			end
		end
		$fclose(fd);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== bench/uart_string_stim.txt ====
# mode len data exp_len exp_string exp_ovf, hex strings hold byte 0 in the rightmost digits
# L sends data as a string, W puts raw bytes on the line, exp_len -1 means the frame stays open
L 5 000000000000000000000000006f6c6c6548 5 000000000000000000000000006f6c6c6548 0
L 1 0000000000000000000000000000005a 1 0000000000000000000000000000005a 0
L 16 66656463626139383736353433323130 16 66656463626139383736353433323130 0
L 0 00000000000000000000000000000000 0 00000000000000000000000000000000 0
L 3 00000000000000000000000000622661 3 00000000000000000000000000622661 0
L 5 00000000000000000000007a26792678 5 00000000000000000000007a26792678 0
W 10 0000000000002626626126267a267978 2 00000000000000000000000000006261 0
W 7 00000000000000000026266226612626 3 00000000000000000000000000622661 0
W 16 4e4d4c4b4a4948474645444342412626 -1 00000000000000000000000000000000 0
W 8 0000000000000000262654535251504f 16 504f4e4d4c4b4a494847464544434241 1
L 2 00000000000000000000000000006b6f 2 00000000000000000000000000006b6f 0

// ==== uart_string_handle.f ====
+incdir+common
common/uart_string_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
hdl/string_frame_tx.sv
hdl/string_frame_rx.sv
hdl/uart_string_handle.sv
bench/uart_string_handle_sva.sv
bench/uart_string_handle_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the uart string link testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module uart_string_handle_tb \
	-f uart_string_handle.f \
	--Mdir obj_dir -o uart_string_handle_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/uart_string_handle_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi
exit 0
